// ==== verilog/llc_cfg_pkg.sv ====
// LLC configuration package
// Register bus request and response structs, address map and cache register constants

`default_nettype none

package llc_cfg_pkg;

  // Register bus widths
  localparam int unsigned RegAddrWidth = 12;
  localparam int unsigned RegDataWidth = 32;

  // Upper bound on ways, one enable or flush bit per way in a data word
  localparam int unsigned MaxWays = 32;

  // Request, one cycle with valid set
  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [RegAddrWidth-1:0] addr;
    logic [RegDataWidth-1:0] wdata;
  } reg_req_t;

  // Response, valid pulses one cycle after the request
  typedef struct packed {
    logic                    valid;
    logic [RegDataWidth-1:0] rdata;
    logic                    error;
  } reg_rsp_t;

  // Cache register byte addresses
  localparam logic [RegAddrWidth-1:0] SpmEnAddr   = 12'h000;
  localparam logic [RegAddrWidth-1:0] FlushAddr   = 12'h004;
  localparam logic [RegAddrWidth-1:0] VersionAddr = 12'h008;

  // Start of the ECC manager region
  localparam logic [RegAddrWidth-1:0] EccOffset = 12'h040;

  // Read-only version word
  localparam logic [RegDataWidth-1:0] LlcVersion = 32'h0001_0000;

endpackage

`default_nettype wire

// ==== verilog/llc_ecc_pkg.sv ====
// ECC manager package
// ECC event and bank control structs, bank register layout

`default_nettype none

package llc_ecc_pkg;

  // Each bank owns 16 bytes of register space
  localparam int unsigned BankStride = 16;
  localparam int unsigned FieldWidth = $clog2(BankStride);

  // Field offsets inside one bank
  localparam logic [FieldWidth-1:0] FaultCountOffs = 4'h0;
  localparam logic [FieldWidth-1:0] UncorrOffs     = 4'h4;
  localparam logic [FieldWidth-1:0] ScrubIntOffs   = 4'h8;

  // Saturating fault counter and scrub interval widths
  localparam int unsigned CountWidth    = 16;
  localparam int unsigned IntervalWidth = 16;

  // ECC report of one bank for one cycle
  typedef struct packed {
    logic single_err;
    logic multi_err;
  } ecc_event_t;

  // Per-bank write strobes from the register decoder
  typedef struct packed {
    logic                     clr_count;
    logic                     clr_uncorr;
    logic                     int_we;
    logic [IntervalWidth-1:0] int_data;
  } bank_ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/ecc_bank_monitor.sv ====
// ECC bank monitor
// Saturating fault counter, sticky uncorrectable flag and periodic scrub timer

`timescale 1ns/1ps
`default_nettype none

module ecc_bank_monitor (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  llc_ecc_pkg::ecc_event_t               event_i,
  input  llc_ecc_pkg::bank_ctrl_t               ctrl_i,
  output logic [llc_ecc_pkg::CountWidth-1:0]    count_o,
  output logic                                  uncorr_o,
  output logic [llc_ecc_pkg::IntervalWidth-1:0] interval_o,
  output logic                                  scrub_o
);

  logic [llc_ecc_pkg::CountWidth-1:0]    count_q;
  logic                                  uncorr_q;
  logic [llc_ecc_pkg::IntervalWidth-1:0] interval_q;
  logic [llc_ecc_pkg::IntervalWidth-1:0] timer_q;
  logic                                  fault;
  logic                                  timer_wrap;

  // Single or multi error counts once per cycle
  assign fault = event_i.single_err || event_i.multi_err;

  // Fault counter, clear beats a same-cycle event
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (ctrl_i.clr_count) begin
      count_q <= '0;
    end else if (fault && (count_q != '1)) begin
      count_q <= count_q + 1'b1;
    end
  end

  // Sticky uncorrectable flag
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      uncorr_q <= 1'b0;
    end else if (ctrl_i.clr_uncorr) begin
      uncorr_q <= 1'b0;
    end else if (event_i.multi_err) begin
      uncorr_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      interval_q <= '0;
    end else if (ctrl_i.int_we) begin
      interval_q <= ctrl_i.int_data;
    end
  end

  // Last cycle of an interval of N, so wraps come N cycles apart
  assign timer_wrap = (interval_q != '0) && (timer_q == interval_q - 1'b1);

  // Timer idles at zero while the interval is zero
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      timer_q <= '0;
    end else if (ctrl_i.int_we || timer_wrap || (interval_q == '0)) begin
      timer_q <= '0;
    end else begin
      timer_q <= timer_q + 1'b1;
    end
  end

  assign count_o    = count_q;
  assign uncorr_o   = uncorr_q;
  assign interval_o = interval_q;
  assign scrub_o    = timer_wrap;

  // The count only goes down when software clears it
  a_count_clear_only: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (count_q < $past(count_q)) |-> $past(ctrl_i.clr_count));

endmodule

`default_nettype wire

// ==== verilog/ecc_manager.sv ====
// ECC manager read and scrub logic
// Returns the selected bank field and merges tag and data scrub pulses per way

`timescale 1ns/1ps
`default_nettype none

module ecc_manager #(
  parameter int unsigned NumWays = 4
) (
  input  logic [2*NumWays-1:0][llc_ecc_pkg::CountWidth-1:0]    count_i,
  input  logic [2*NumWays-1:0]                                 uncorr_i,
  input  logic [2*NumWays-1:0][llc_ecc_pkg::IntervalWidth-1:0] interval_i,
  input  logic [2*NumWays-1:0]                                 scrub_i,
  input  logic [$clog2(2*NumWays)-1:0]                         bank_sel_i,
  input  logic [llc_ecc_pkg::FieldWidth-1:0]                   field_sel_i,
  output logic [llc_cfg_pkg::RegDataWidth-1:0]                 rdata_o,
  output logic [NumWays-1:0]                                   scrub_trigger_o
);

  localparam int unsigned NumBanks = 2 * NumWays;

  // Field read, zero-extended to the bus width
  always_comb begin
    rdata_o = '0;
    // Selects past the last bank are flagged by the decoder
    if (bank_sel_i < NumBanks) begin
      case (field_sel_i)
        llc_ecc_pkg::FaultCountOffs: begin
          rdata_o[llc_ecc_pkg::CountWidth-1:0] = count_i[bank_sel_i];
        end
        llc_ecc_pkg::UncorrOffs: begin
          rdata_o[0] = uncorr_i[bank_sel_i];
        end
        llc_ecc_pkg::ScrubIntOffs: begin
          rdata_o[llc_ecc_pkg::IntervalWidth-1:0] = interval_i[bank_sel_i];
        end
        default: begin
          rdata_o = '0;
        end
      endcase
    end
  end

  // Lower half of the banks are tags, upper half data
  // Either one asks the cache to scrub that way
  assign scrub_trigger_o = scrub_i[NumWays-1:0] | scrub_i[NumBanks-1:NumWays];

endmodule

`default_nettype wire

// ==== verilog/llc_cfg_regs.sv ====
// LLC cache configuration registers
// Scratch-pad enable mask, pending flush mask and read-only version

`timescale 1ns/1ps
`default_nettype none

module llc_cfg_regs #(
  parameter int unsigned NumWays = 4
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 we_i,
  input  logic [llc_cfg_pkg::RegAddrWidth-1:0] addr_i,
  input  logic [llc_cfg_pkg::RegDataWidth-1:0] wdata_i,
  output logic [llc_cfg_pkg::RegDataWidth-1:0] rdata_o,
  input  logic [NumWays-1:0]                   flush_done_i,
  output logic [NumWays-1:0]                   spm_en_o,
  output logic [NumWays-1:0]                   flush_o
);

  logic [NumWays-1:0] spm_en_q;
  logic [NumWays-1:0] flush_q;
  logic [NumWays-1:0] flush_set;
  logic               flush_we;

  // Write data trimmed to the ways that exist
  assign flush_we  = we_i && (addr_i == llc_cfg_pkg::FlushAddr);
  assign flush_set = flush_we ? wdata_i[NumWays-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      spm_en_q <= '0;
    end else if (we_i && (addr_i == llc_cfg_pkg::SpmEnAddr)) begin
      spm_en_q <= wdata_i[NumWays-1:0];
    end
  end

  // Writes only set bits, done clears them
  // Clear wins when both hit the same way
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      flush_q <= '0;
    end else begin
      flush_q <= (flush_q | flush_set) & ~flush_done_i;
    end
  end

  assign spm_en_o = spm_en_q;
  assign flush_o  = flush_q;

  // Read mux, masks zero-extended to the bus width
  always_comb begin
    rdata_o = '0;
    case (addr_i)
      llc_cfg_pkg::SpmEnAddr: begin
        rdata_o[NumWays-1:0] = spm_en_q;
      end
      llc_cfg_pkg::FlushAddr: begin
        rdata_o[NumWays-1:0] = flush_q;
      end
      // Version ignores writes
      llc_cfg_pkg::VersionAddr: begin
        rdata_o = llc_cfg_pkg::LlcVersion;
      end
      default: begin
        rdata_o = '0;
      end
    endcase
  end

  // A pending flush bit only appears after a flush register write
  a_flush_needs_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ((flush_q & ~$past(flush_q)) != '0) |-> $past(flush_we));

endmodule

`default_nettype wire

// ==== verilog/llc_reg_demux.sv ====
// LLC register demux
// Steers bus requests to cache registers or ECC banks, registers the response

`timescale 1ns/1ps
`default_nettype none

module llc_reg_demux #(
  parameter int unsigned NumWays = 4
) (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  input  llc_cfg_pkg::reg_req_t                            req_i,
  output llc_cfg_pkg::reg_rsp_t                            rsp_o,
  output logic                                             cfg_we_o,
  output logic [llc_cfg_pkg::RegAddrWidth-1:0]             cfg_addr_o,
  output logic [llc_cfg_pkg::RegDataWidth-1:0]             cfg_wdata_o,
  input  logic [llc_cfg_pkg::RegDataWidth-1:0]             cfg_rdata_i,
  output llc_ecc_pkg::bank_ctrl_t [2*NumWays-1:0]          bank_ctrl_o,
  output logic [$clog2(2*NumWays)-1:0]                     ecc_bank_sel_o,
  output logic [llc_ecc_pkg::FieldWidth-1:0]               ecc_field_sel_o,
  input  logic [llc_cfg_pkg::RegDataWidth-1:0]             ecc_rdata_i
);

  localparam int unsigned NumBanks     = 2 * NumWays;
  localparam int unsigned BankIdxWidth = $clog2(NumBanks);
  localparam int unsigned AddrWidth    = llc_cfg_pkg::RegAddrWidth;
  localparam int unsigned FieldWidth   = llc_ecc_pkg::FieldWidth;

  logic                               is_cfg;
  logic                               is_ecc;
  logic                               ecc_wr;
  logic [AddrWidth-1:0]               ecc_addr;
  logic [AddrWidth-FieldWidth-1:0]    bank_full;
  logic [FieldWidth-1:0]              field;
  logic                               field_ok;
  logic [llc_cfg_pkg::RegDataWidth-1:0] rdata_mux;
  logic                               rsp_valid_q;
  logic                               rsp_err_q;
  logic [llc_cfg_pkg::RegDataWidth-1:0] rsp_rdata_q;

  // Only the three cache words are mapped below the ECC region
  assign is_cfg = (req_i.addr == llc_cfg_pkg::SpmEnAddr) ||
                  (req_i.addr == llc_cfg_pkg::FlushAddr) ||
                  (req_i.addr == llc_cfg_pkg::VersionAddr);

  // Rebase into the ECC region, then split into bank and field
  assign ecc_addr  = req_i.addr - llc_cfg_pkg::EccOffset;
  assign bank_full = ecc_addr[AddrWidth-1:FieldWidth];
  assign field     = ecc_addr[FieldWidth-1:0];
  assign field_ok  = (field == llc_ecc_pkg::FaultCountOffs) ||
                     (field == llc_ecc_pkg::UncorrOffs) ||
                     (field == llc_ecc_pkg::ScrubIntOffs);
  assign is_ecc    = (req_i.addr >= llc_cfg_pkg::EccOffset) && (bank_full < NumBanks) && field_ok;

  // Cache register side
  assign cfg_we_o    = req_i.valid && req_i.write && is_cfg;
  assign cfg_addr_o  = req_i.addr;
  assign cfg_wdata_o = req_i.wdata;

  // ECC read select
  assign ecc_bank_sel_o  = bank_full[BankIdxWidth-1:0];
  assign ecc_field_sel_o = field;

  // Per-bank strobes, writes only
  assign ecc_wr = req_i.valid && req_i.write && is_ecc;

  always_comb begin
    for (int unsigned b = 0; b < NumBanks; b++) begin
      bank_ctrl_o[b].clr_count  = ecc_wr && (bank_full == b) &&
                                  (field == llc_ecc_pkg::FaultCountOffs);
      bank_ctrl_o[b].clr_uncorr = ecc_wr && (bank_full == b) &&
                                  (field == llc_ecc_pkg::UncorrOffs);
      bank_ctrl_o[b].int_we     = ecc_wr && (bank_full == b) &&
                                  (field == llc_ecc_pkg::ScrubIntOffs);
      // Interval data is shared, only the strobe selects the bank
      bank_ctrl_o[b].int_data   = req_i.wdata[llc_ecc_pkg::IntervalWidth-1:0];
    end
  end

  // Read data pick, zero on writes and unmapped accesses
  always_comb begin
    rdata_mux = '0;
    if (!req_i.write && is_cfg) begin
      rdata_mux = cfg_rdata_i;
    end else if (!req_i.write && is_ecc) begin
      rdata_mux = ecc_rdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.valid;
    end
  end

  // Response payload, captured with each request
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rsp_rdata_q <= rdata_mux;
      rsp_err_q   <= !(is_cfg || is_ecc);
    end
  end

  assign rsp_o = '{valid: rsp_valid_q, rdata: rsp_rdata_q, error: rsp_err_q};

  // An error response never carries read data
  a_err_zero_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (rsp_o.valid && rsp_o.error) |-> (rsp_o.rdata == '0));

endmodule

`default_nettype wire

// ==== verilog/llc_cfg_top.sv ====
// LLC configuration and ECC front end
// Register demux, cache registers, per-bank ECC monitors and ECC manager

`timescale 1ns/1ps
`default_nettype none

module llc_cfg_top #(
  parameter int unsigned NumWays = 4
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  llc_cfg_pkg::reg_req_t                 req_i,
  output llc_cfg_pkg::reg_rsp_t                 rsp_o,
  input  llc_ecc_pkg::ecc_event_t [NumWays-1:0] tag_ecc_i,
  input  llc_ecc_pkg::ecc_event_t [NumWays-1:0] data_ecc_i,
  input  logic [NumWays-1:0]                    flush_done_i,
  output logic [NumWays-1:0]                    spm_en_o,
  output logic [NumWays-1:0]                    flush_o,
  output logic [NumWays-1:0]                    scrub_trigger_o
);

  localparam int unsigned NumBanks     = 2 * NumWays;
  localparam int unsigned BankIdxWidth = $clog2(NumBanks);

  // One mask bit per way must fit in a data word
  if ((NumWays < 1) || (NumWays > llc_cfg_pkg::MaxWays)) begin : gen_bad_ways
    $error("NumWays out of range");
  end

  logic                                                cfg_we;
  logic [llc_cfg_pkg::RegAddrWidth-1:0]                cfg_addr;
  logic [llc_cfg_pkg::RegDataWidth-1:0]                cfg_wdata;
  logic [llc_cfg_pkg::RegDataWidth-1:0]                cfg_rdata;
  llc_ecc_pkg::bank_ctrl_t [NumBanks-1:0]              bank_ctrl;
  logic [BankIdxWidth-1:0]                             bank_sel;
  logic [llc_ecc_pkg::FieldWidth-1:0]                  field_sel;
  logic [llc_cfg_pkg::RegDataWidth-1:0]                ecc_rdata;
  llc_ecc_pkg::ecc_event_t [NumBanks-1:0]              bank_event;
  logic [NumBanks-1:0][llc_ecc_pkg::CountWidth-1:0]    count;
  logic [NumBanks-1:0]                                 uncorr;
  logic [NumBanks-1:0][llc_ecc_pkg::IntervalWidth-1:0] interval;
  logic [NumBanks-1:0]                                 scrub;

  // Tag banks first, data banks after
  assign bank_event = {data_ecc_i, tag_ecc_i};

  llc_reg_demux #(
    .NumWays ( NumWays )
  ) i_llc_reg_demux (
    .clk_i           ( clk_i     ),
    .arst_n_i        ( arst_n_i  ),
    .req_i           ( req_i     ),
    .rsp_o           ( rsp_o     ),
    .cfg_we_o        ( cfg_we    ),
    .cfg_addr_o      ( cfg_addr  ),
    .cfg_wdata_o     ( cfg_wdata ),
    .cfg_rdata_i     ( cfg_rdata ),
    .bank_ctrl_o     ( bank_ctrl ),
    .ecc_bank_sel_o  ( bank_sel  ),
    .ecc_field_sel_o ( field_sel ),
    .ecc_rdata_i     ( ecc_rdata )
  );

  llc_cfg_regs #(
    .NumWays ( NumWays )
  ) i_llc_cfg_regs (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .we_i         ( cfg_we       ),
    .addr_i       ( cfg_addr     ),
    .wdata_i      ( cfg_wdata    ),
    .rdata_o      ( cfg_rdata    ),
    .flush_done_i ( flush_done_i ),
    .spm_en_o     ( spm_en_o     ),
    .flush_o      ( flush_o      )
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    ecc_bank_monitor i_ecc_bank_monitor (
      .clk_i      ( clk_i         ),
      .arst_n_i   ( arst_n_i      ),
      .event_i    ( bank_event[b] ),
      .ctrl_i     ( bank_ctrl[b]  ),
      .count_o    ( count[b]      ),
      .uncorr_o   ( uncorr[b]     ),
      .interval_o ( interval[b]   ),
      .scrub_o    ( scrub[b]      )
    );
  end

  ecc_manager #(
    .NumWays ( NumWays )
  ) i_ecc_manager (
    .count_i         ( count           ),
    .uncorr_i        ( uncorr          ),
    .interval_i      ( interval        ),
    .scrub_i         ( scrub           ),
    .bank_sel_i      ( bank_sel        ),
    .field_sel_i     ( field_sel       ),
    .rdata_o         ( ecc_rdata       ),
    .scrub_trigger_o ( scrub_trigger_o )
  );

endmodule

`default_nettype wire

// ==== bench/llc_cfg_tb.sv ====
// LLC configuration front end testbench
// Table-driven bus accesses, ECC event injection, flush and scrub timing checks

`timescale 1ns/1ps
`default_nettype none

module llc_cfg_tb;

  localparam int num_ways = 4;
  localparam logic [31:0] way_mask = (32'd1 << num_ways) - 1;

  // Step operations
  localparam int op_write     = 0;
  localparam int op_read      = 1;
  localparam int op_inj_sbe   = 2;
  localparam int op_inj_mbe   = 3;
  localparam int op_done      = 4;
  localparam int op_chk_spm   = 5;
  localparam int op_chk_flush = 6;
  localparam int op_scrub     = 7;

  // One table entry, for injects addr is the bank and wdata the event count
  typedef struct {
    string       name;
    int          op;
    logic [11:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
  } step_t;

  logic                                     clk_i;
  logic                                     arst_n_i;
  llc_cfg_pkg::reg_req_t                    req;
  llc_cfg_pkg::reg_rsp_t                    rsp;
  llc_ecc_pkg::ecc_event_t [num_ways-1:0]   tag_ecc;
  llc_ecc_pkg::ecc_event_t [num_ways-1:0]   data_ecc;
  logic [num_ways-1:0]                      flush_done;
  logic [num_ways-1:0]                      spm_en;
  logic [num_ways-1:0]                      flush;
  logic [num_ways-1:0]                      scrub_trigger;

  step_t steps[$];
  int    errors;
  int    timeouts;
  int    k;

  llc_cfg_top #(
    .NumWays ( num_ways )
  ) llc_cfg_top_i (
    .clk_i           ( clk_i         ),
    .arst_n_i        ( arst_n_i      ),
    .req_i           ( req           ),
    .rsp_o           ( rsp           ),
    .tag_ecc_i       ( tag_ecc       ),
    .data_ecc_i      ( data_ecc      ),
    .flush_done_i    ( flush_done    ),
    .spm_en_o        ( spm_en        ),
    .flush_o         ( flush         ),
    .scrub_trigger_o ( scrub_trigger )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  // Byte address of one field of one ECC bank
  function automatic logic [11:0] bank_addr(input int bank, input logic [3:0] field);
    return llc_cfg_pkg::EccOffset + 12'(bank * llc_ecc_pkg::BankStride) + 12'(field);
  endfunction

  task automatic add_step(input string name, input int op, input logic [11:0] addr,
                          input logic [31:0] wdata, input logic [31:0] exp_rdata,
                          input logic exp_err);
    step_t s;
    s.name      = name;
    s.op        = op;
    s.addr      = addr;
    s.wdata     = wdata;
    s.exp_rdata = exp_rdata;
    s.exp_err   = exp_err;
    steps.push_back(s);
  endtask

  // Single-cycle request, then poll for the response pulse
  task automatic bus_access(input step_t s);
    int   cyc;
    logic got;
    cyc = 0;
    got = 1'b0;
    req = '{valid: 1'b1, write: (s.op == op_write), addr: s.addr, wdata: s.wdata};
    while (!got && cyc < 10) begin
      @(posedge clk_i);
      #1;
      req.valid = 1'b0;
      got = rsp.valid;
      cyc++;
    end
    if (!got) begin
      $display("Timeout in %s, no bus response after %0d cycles", s.name, cyc);
      timeouts++;
    end else begin
      // Response is due exactly one cycle after the request
      check_value({s.name, " latency"}, 32'd1, 32'(cyc));
      check_value({s.name, " rdata"}, s.exp_rdata, rsp.rdata);
      check_value({s.name, " error"}, 32'(s.exp_err), 32'(rsp.error));
    end
  endtask

  // Hold an event on one bank for n cycles
  task automatic inject_events(input int bank, input int n, input logic multi);
    llc_ecc_pkg::ecc_event_t ev;
    ev = '{single_err: !multi, multi_err: multi};
    if (bank < num_ways) tag_ecc[bank] = ev;
    else data_ecc[bank-num_ways] = ev;
    for (int c = 0; c < n; c++) begin
      @(posedge clk_i);
      #1;
    end
    tag_ecc  = '0;
    data_ecc = '0;
  endtask

  task automatic pulse_flush_done(input logic [num_ways-1:0] mask);
    flush_done = mask;
    @(posedge clk_i);
    #1;
    flush_done = '0;
  endtask

  // Spacing of consecutive pulses on one way, or none seen in 30 cycles
  task automatic measure_scrub(input string name, input int way, input int spacing);
    int wait_cyc;
    int gap;
    int pulses;
    wait_cyc = 0;
    pulses   = 0;
    if (spacing == 0) begin
      for (int c = 0; c < 30; c++) begin
        @(posedge clk_i);
        #1;
        if (scrub_trigger[way]) pulses++;
      end
      check_value({name, " pulses"}, 32'd0, 32'(pulses));
    end else begin
      while (!scrub_trigger[way] && wait_cyc < 100) begin
        @(posedge clk_i);
        #1;
        wait_cyc++;
      end
      if (!scrub_trigger[way]) begin
        $display("Timeout in %s, no scrub pulse on way %0d", name, way);
        timeouts++;
      end else begin
        for (int p = 0; p < 2; p++) begin
          gap = 0;
          do begin
            @(posedge clk_i);
            #1;
            gap++;
          end while (!scrub_trigger[way] && gap < 100);
          check_value({name, " spacing"}, 32'(spacing), 32'(gap));
        end
      end
    end
  endtask

  task automatic build_table();
    // Scratch-pad enable and flush
    add_step("spm write", op_write, llc_cfg_pkg::SpmEnAddr, 32'hffff_ffa5, 32'h0, 1'b0);
    add_step("spm read", op_read, llc_cfg_pkg::SpmEnAddr, 32'h0, 32'hffff_ffa5 & way_mask, 1'b0);
    add_step("spm port", op_chk_spm, '0, 32'h0, 32'hffff_ffa5 & way_mask, 1'b0);
    add_step("flush write", op_write, llc_cfg_pkg::FlushAddr, 32'h0000_000b, 32'h0, 1'b0);
    add_step("flush port set", op_chk_flush, '0, 32'h0, 32'h0000_000b, 1'b0);
    add_step("flush done 0 1", op_done, '0, 32'h3, 32'h0, 1'b0);
    add_step("flush port left", op_chk_flush, '0, 32'h0, 32'hb & ~32'h3, 1'b0);
    add_step("flush read left", op_read, llc_cfg_pkg::FlushAddr, 32'h0, 32'hb & ~32'h3, 1'b0);
    add_step("flush done 3", op_done, '0, 32'h8, 32'h0, 1'b0);
    add_step("flush port empty", op_chk_flush, '0, 32'h0, 32'h0, 1'b0);
    // Version and unmapped space
    add_step("version read", op_read, llc_cfg_pkg::VersionAddr, 32'h0, llc_cfg_pkg::LlcVersion, 1'b0);
    add_step("version write", op_write, llc_cfg_pkg::VersionAddr, 32'hdead_beef, 32'h0, 1'b0);
    add_step("version reread", op_read, llc_cfg_pkg::VersionAddr, 32'h0, llc_cfg_pkg::LlcVersion, 1'b0);
    add_step("gap read", op_read, 12'h020, 32'h0, 32'h0, 1'b1);
    add_step("gap write", op_write, 12'h020, 32'h1234_5678, 32'h0, 1'b1);
    add_step("past banks read", op_read, bank_addr(2*num_ways, 4'h0), 32'h0, 32'h0, 1'b1);
    add_step("past banks write", op_write, bank_addr(2*num_ways, 4'h0), 32'h1, 32'h0, 1'b1);
    add_step("bad field read", op_read, bank_addr(0, 4'hc), 32'h0, 32'h0, 1'b1);
    // Fault counting, tag bank 1 and data way 2
    add_step("inject sbe bank 1", op_inj_sbe, 12'd1, 32'(k), 32'h0, 1'b0);
    add_step("count bank 1", op_read, bank_addr(1, llc_ecc_pkg::FaultCountOffs), 32'h0, 32'(k), 1'b0);
    add_step("inject mbe bank 6", op_inj_mbe, 12'd6, 32'd1, 32'h0, 1'b0);
    add_step("uncorr bank 6", op_read, bank_addr(6, llc_ecc_pkg::UncorrOffs), 32'h0, 32'h1, 1'b0);
    add_step("count bank 6", op_read, bank_addr(6, llc_ecc_pkg::FaultCountOffs), 32'h0, 32'h1, 1'b0);
    add_step("clear count 1", op_write, bank_addr(1, llc_ecc_pkg::FaultCountOffs), 32'h0, 32'h0, 1'b0);
    add_step("count 1 cleared", op_read, bank_addr(1, llc_ecc_pkg::FaultCountOffs), 32'h0, 32'h0, 1'b0);
    add_step("clear count 6", op_write, bank_addr(6, llc_ecc_pkg::FaultCountOffs), 32'h5, 32'h0, 1'b0);
    add_step("count 6 cleared", op_read, bank_addr(6, llc_ecc_pkg::FaultCountOffs), 32'h0, 32'h0, 1'b0);
    add_step("clear uncorr 6", op_write, bank_addr(6, llc_ecc_pkg::UncorrOffs), 32'h0, 32'h0, 1'b0);
    add_step("uncorr 6 cleared", op_read, bank_addr(6, llc_ecc_pkg::UncorrOffs), 32'h0, 32'h0, 1'b0);
    add_step("count bank 0", op_read, bank_addr(0, llc_ecc_pkg::FaultCountOffs), 32'h0, 32'h0, 1'b0);
    add_step("count bank 7", op_read, bank_addr(7, llc_ecc_pkg::FaultCountOffs), 32'h0, 32'h0, 1'b0);
    add_step("uncorr bank 1", op_read, bank_addr(1, llc_ecc_pkg::UncorrOffs), 32'h0, 32'h0, 1'b0);
    // Scrub timers feeding way 3
    add_step("interval 3 write", op_write, bank_addr(3, llc_ecc_pkg::ScrubIntOffs), 32'd7, 32'h0, 1'b0);
    add_step("interval 3 read", op_read, bank_addr(3, llc_ecc_pkg::ScrubIntOffs), 32'h0, 32'd7, 1'b0);
    add_step("scrub tag way 3", op_scrub, 12'd3, 32'd7, 32'h0, 1'b0);
    add_step("interval 3 off", op_write, bank_addr(3, llc_ecc_pkg::ScrubIntOffs), 32'd0, 32'h0, 1'b0);
    add_step("interval 7 write", op_write, bank_addr(7, llc_ecc_pkg::ScrubIntOffs), 32'd5, 32'h0, 1'b0);
    add_step("scrub data way 3", op_scrub, 12'd3, 32'd5, 32'h0, 1'b0);
    add_step("interval 7 off", op_write, bank_addr(7, llc_ecc_pkg::ScrubIntOffs), 32'd0, 32'h0, 1'b0);
    add_step("scrub stopped", op_scrub, 12'd3, 32'd0, 32'h0, 1'b0);
  endtask

  initial begin
    errors     = 0;
    timeouts   = 0;
    arst_n_i   = 1'b0;
    req        = '0;
    tag_ecc    = '0;
    data_ecc   = '0;
    flush_done = '0;
    void'($urandom(32'h87c4_676b));
    k = $urandom_range(20, 1);
    build_table();

    repeat (4) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    @(posedge clk_i);
    #1;

    // Everything idle out of reset
    check_value("reset rsp valid", 32'h0, 32'(rsp.valid));
    check_value("reset spm_en", 32'h0, 32'(spm_en));
    check_value("reset flush", 32'h0, 32'(flush));
    check_value("reset scrub", 32'h0, 32'(scrub_trigger));

    foreach (steps[i]) begin
      case (steps[i].op)
        op_write, op_read: bus_access(steps[i]);
        op_inj_sbe: inject_events(int'(steps[i].addr), int'(steps[i].wdata), 1'b0);
        op_inj_mbe: inject_events(int'(steps[i].addr), int'(steps[i].wdata), 1'b1);
        op_done: pulse_flush_done(steps[i].wdata[num_ways-1:0]);
        op_chk_spm: check_value(steps[i].name, steps[i].exp_rdata, 32'(spm_en));
        op_chk_flush: check_value(steps[i].name, steps[i].exp_rdata, 32'(flush));
        op_scrub: measure_scrub(steps[i].name, int'(steps[i].addr), int'(steps[i].wdata));
        default: begin
          $display("Unknown operation in step %s", steps[i].name);
          errors++;
        end
      endcase
    end

    $display("Mismatches: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== llc_cfg.f ====
verilog/llc_cfg_pkg.sv
verilog/llc_ecc_pkg.sv
verilog/ecc_bank_monitor.sv
verilog/ecc_manager.sv
verilog/llc_cfg_regs.sv
verilog/llc_reg_demux.sv
verilog/llc_cfg_top.sv
bench/llc_cfg_tb.sv

// ==== Makefile ====
# Verilator build and run of the LLC configuration front end testbench

VERILATOR ?= verilator
TOP       ?= llc_cfg_tb
FILELIST  ?= llc_cfg.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
